//--- logic/counter_memory_pkg.sv
package counter_memory_pkg;

  // ----------------------------------------------------------
  // Operation carried through each bank pipeline stage.
  // ----------------------------------------------------------
  typedef enum logic [1:0] {
    op_none       = 2'd0,
    op_count      = 2'd1,
    op_host_write = 2'd2,
    op_host_read  = 2'd3
  } bank_op_e;

  // Row clear sequencer state.
  typedef enum logic {
    st_clear = 1'b0,
    st_run   = 1'b1
  } clear_state_e;

  // ----------------------------------------------------------
  // Default sizes, passed down from the top level.
  // ----------------------------------------------------------

  // Counter word width in bits.
  localparam int default_width = 16;

  // Number of counter rows.
  localparam int default_num_addr = 64;

  // Number of counter ports, one partial-sum bank each.
  localparam int default_num_cnt_ports = 3;

  // Memory read latency in cycles
  localparam int default_sram_delay = 2;

endpackage

//--- logic/sram_1r1w.sv
`timescale 1ns/100ps

module sram_1r1w #(
  parameter int WIDTH      = 16,
  parameter int NUM_ADDR   = 64,
  parameter int SRAM_DELAY = 2
) (
  input  logic                        clk,
  input  logic                        write,
  input  logic [$clog2(NUM_ADDR)-1:0] wr_adr,
  input  logic [WIDTH-1:0]            wr_din,
  input  logic                        read,
  input  logic [$clog2(NUM_ADDR)-1:0] rd_adr,
  output logic [WIDTH-1:0]            rd_dout
);

  logic [WIDTH-1:0] mem     [NUM_ADDR];
  logic [WIDTH-1:0] rd_pipe [SRAM_DELAY];

  always_ff @(posedge clk) begin
    if (write) begin
      mem[wr_adr] <= wr_din;
    end
  end

  // A same-cycle write is not seen by the read.
  always_ff @(posedge clk) begin
    if (read) begin
      rd_pipe[0] <= mem[rd_adr];
    end
    for (int k = 1; k < SRAM_DELAY; k++) begin
      rd_pipe[k] <= rd_pipe[k-1];
    end
  end

  assign rd_dout = rd_pipe[SRAM_DELAY-1];

endmodule

//--- logic/row_clear_sequencer.sv
`timescale 1ns/100ps

module row_clear_sequencer #(
  parameter int NUM_ADDR = 64
) (
  input  logic                        clk,
  input  logic                        reset,
  output logic                        ready,
  output logic [$clog2(NUM_ADDR)-1:0] clear_addr
);
  import counter_memory_pkg::*;

  localparam int ADDR_W = $clog2(NUM_ADDR);

  clear_state_e state;

  // Sweep every row once, one per cycle, then hand over to normal operation.
  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= st_clear;
      clear_addr <= '0;
    end else begin
      case (state)
        st_clear: begin
          if (clear_addr == ADDR_W'(NUM_ADDR - 1)) begin
            state <= st_run;
          end else begin
            clear_addr <= clear_addr + 1'b1;
          end
        end
        default: begin
          state <= st_run;
        end
      endcase
    end
  end

  assign ready = (state == st_run);

  // Once up, the memory stays up until the next reset.
  a_ready_stays_high: assert property (@(posedge clk) disable iff (reset) ready |=> ready)
    else $error("ready fell without reset");

endmodule

//--- logic/partial_sum_bank.sv
`timescale 1ns/100ps

module partial_sum_bank #(
  parameter int WIDTH      = 16,
  parameter int NUM_ADDR   = 64,
  parameter int SRAM_DELAY = 2,
  parameter int BANK_INDEX = 0
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        ready,
  input  logic [$clog2(NUM_ADDR)-1:0] clear_addr,
  input  logic                        cnt,
  input  logic [$clog2(NUM_ADDR)-1:0] ct_adr,
  input  logic [WIDTH-1:0]            imm,
  input  logic                        read,
  input  logic                        write,
  input  logic [$clog2(NUM_ADDR)-1:0] addr,
  input  logic [WIDTH-1:0]            din,
  output logic                        ct_vld,
  output logic                        part_vld,
  output logic [WIDTH-1:0]            part_dout
);
  import counter_memory_pkg::*;

  localparam int ADDR_W = $clog2(NUM_ADDR);
  localparam int LAST   = SRAM_DELAY;

  bank_op_e          stage_op      [LAST+1];
  logic [ADDR_W-1:0] stage_adr     [LAST+1];
  logic [WIDTH-1:0]  stage_val     [LAST+1];
  logic              stage_fwd     [LAST+1];
  logic [WIDTH-1:0]  stage_fwd_val [LAST+1];

  bank_op_e          new_op;
  logic              mem_read;
  logic              mem_write;
  logic [ADDR_W-1:0] mem_wr_adr;
  logic [WIDTH-1:0]  mem_wr_din;
  logic [WIDTH-1:0]  mem_rd_dout;
  logic [WIDTH-1:0]  old_val;
  logic              wb_en;
  logic [WIDTH-1:0]  wb_val;

  // ----------------------------------------------------------
  // Command tagging and pipeline.
  // ----------------------------------------------------------
  always_comb begin
    if (!ready) new_op = op_none;
    else if (cnt) new_op = op_count;
    else if (write) new_op = op_host_write;
    else if (read) new_op = op_host_read;
    else new_op = op_none;
  end

  // An item picks up any write-back to its row made after its memory read.
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int k = 0; k <= LAST; k++) begin
        stage_op[k]  <= op_none;
        stage_fwd[k] <= 1'b0;
      end
    end else begin
      stage_op[0]  <= new_op;
      stage_fwd[0] <= 1'b0;
      for (int k = 1; k <= LAST; k++) begin
        stage_op[k]  <= stage_op[k-1];
        stage_fwd[k] <= stage_fwd[k-1] || (wb_en && stage_adr[k-1] == stage_adr[LAST]);
      end
    end
  end

  always_ff @(posedge clk) begin
    stage_adr[0]     <= cnt ? ct_adr : addr;
    stage_val[0]     <= cnt ? imm : din;
    stage_fwd_val[0] <= '0;
    for (int k = 1; k <= LAST; k++) begin
      stage_adr[k] <= stage_adr[k-1];
      stage_val[k] <= stage_val[k-1];
      if (wb_en && stage_adr[k-1] == stage_adr[LAST]) stage_fwd_val[k] <= wb_val;
      else stage_fwd_val[k] <= stage_fwd_val[k-1];
    end
  end

  // ----------------------------------------------------------
  // Last stage: write-back and results.
  // ----------------------------------------------------------
  assign old_val = stage_fwd[LAST] ? stage_fwd_val[LAST] : mem_rd_dout;

  always_comb begin
    wb_en = (stage_op[LAST] == op_count) || (stage_op[LAST] == op_host_write);
    if (stage_op[LAST] == op_count) wb_val = old_val + stage_val[LAST];
    else if (BANK_INDEX == 0) wb_val = stage_val[LAST];
    else wb_val = '0;
  end

  // Clear pass owns the write port until ready.
  assign mem_read   = (stage_op[0] == op_count) || (stage_op[0] == op_host_read);
  assign mem_write  = !ready || wb_en;
  assign mem_wr_adr = ready ? stage_adr[LAST] : clear_addr;
  assign mem_wr_din = ready ? wb_val : '0;

  assign ct_vld    = (stage_op[LAST] == op_count);
  assign part_vld  = (stage_op[LAST] == op_host_read);
  assign part_dout = old_val;

  sram_1r1w #(.WIDTH(WIDTH), .NUM_ADDR(NUM_ADDR), .SRAM_DELAY(SRAM_DELAY)) u_mem (
    .clk     (clk),
    .write   (mem_write),
    .wr_adr  (mem_wr_adr),
    .wr_din  (mem_wr_din),
    .read    (mem_read),
    .rd_adr  (stage_adr[0]),
    .rd_dout (mem_rd_dout)
  );

  a_one_command: assert property (@(posedge clk) disable iff (reset)
    $onehot0({read, write, cnt}))
    else $error("more than one command in a cycle");

  a_no_command_before_ready: assert property (@(posedge clk) disable iff (reset)
    !ready |-> !(read || write || cnt))
    else $error("command while clear pass is running");

endmodule

//--- logic/read_sum_collector.sv
`timescale 1ns/100ps

module read_sum_collector #(
  parameter int WIDTH         = 16,
  parameter int NUM_CNT_PORTS = 3
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [NUM_CNT_PORTS-1:0]       part_vld,
  input  logic [NUM_CNT_PORTS*WIDTH-1:0] part_dout,
  output logic                           rd_vld,
  output logic [WIDTH-1:0]               rd_dout
);

  logic [WIDTH-1:0] sum;

  // Sum wraps modulo 2**WIDTH.
  always_comb begin
    sum = '0;
    for (int i = 0; i < NUM_CNT_PORTS; i++) begin
      sum = sum + part_dout[i*WIDTH +: WIDTH];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) rd_vld <= 1'b0;
    else rd_vld <= |part_vld;
  end

  always_ff @(posedge clk) begin
    rd_dout <= sum;
  end

  // Every bank sees the same host read at the same time.
  a_banks_agree: assert property (@(posedge clk) disable iff (reset)
    (&part_vld) || !(|part_vld))
    else $error("partial read valids disagree across banks");

endmodule

//--- logic/counter_memory_top.sv
`timescale 1ns/100ps

module counter_memory_top #(
  parameter int WIDTH         = counter_memory_pkg::default_width,
  parameter int NUM_ADDR      = counter_memory_pkg::default_num_addr,
  parameter int NUM_CNT_PORTS = counter_memory_pkg::default_num_cnt_ports,
  parameter int SRAM_DELAY    = counter_memory_pkg::default_sram_delay
) (
  input  logic                                        clk,
  input  logic                                        reset,
  output logic                                        ready,
  input  logic [NUM_CNT_PORTS-1:0]                    cnt,
  input  logic [NUM_CNT_PORTS*$clog2(NUM_ADDR)-1:0]   ct_adr,
  input  logic [NUM_CNT_PORTS*WIDTH-1:0]              imm,
  output logic [NUM_CNT_PORTS-1:0]                    ct_vld,
  input  logic                                        read,
  input  logic                                        write,
  input  logic [$clog2(NUM_ADDR)-1:0]                 addr,
  input  logic [WIDTH-1:0]                            din,
  output logic                                        rd_vld,
  output logic [WIDTH-1:0]                            rd_dout
);

  localparam int ADDR_W = $clog2(NUM_ADDR);

  logic [ADDR_W-1:0]              clear_addr;
  logic [NUM_CNT_PORTS-1:0]       part_vld;
  logic [NUM_CNT_PORTS*WIDTH-1:0] part_dout;

  row_clear_sequencer #(.NUM_ADDR(NUM_ADDR)) u_clear (
    .clk        (clk),
    .reset      (reset),
    .ready      (ready),
    .clear_addr (clear_addr)
  );

  // One private partial-sum bank per counter port.
  generate
    for (genvar i = 0; i < NUM_CNT_PORTS; i++) begin : g_bank
      partial_sum_bank #(
        .WIDTH      (WIDTH),
        .NUM_ADDR   (NUM_ADDR),
        .SRAM_DELAY (SRAM_DELAY),
        .BANK_INDEX (i)
      ) u_bank (
        .clk        (clk),
        .reset      (reset),
        .ready      (ready),
        .clear_addr (clear_addr),
        .cnt        (cnt[i]),
        .ct_adr     (ct_adr[i*ADDR_W +: ADDR_W]),
        .imm        (imm[i*WIDTH +: WIDTH]),
        .read       (read),
        .write      (write),
        .addr       (addr),
        .din        (din),
        .ct_vld     (ct_vld[i]),
        .part_vld   (part_vld[i]),
        .part_dout  (part_dout[i*WIDTH +: WIDTH])
      );
    end
  endgenerate

  read_sum_collector #(.WIDTH(WIDTH), .NUM_CNT_PORTS(NUM_CNT_PORTS)) u_sum (
    .clk       (clk),
    .reset     (reset),
    .part_vld  (part_vld),
    .part_dout (part_dout),
    .rd_vld    (rd_vld),
    .rd_dout   (rd_dout)
  );

endmodule

//--- testbench/counter_memory_tests.svh
// ----------------------------------------------------------
// Directed tests.
// ----------------------------------------------------------
task automatic check_clear_after_reset();
  int waited;
  begin_test("clear_after_reset");
  waited = 0;
  while (!ready && waited < NUM_ADDR + 2) begin
    next_cycle();
    waited++;
  end
  if (!ready) begin
    errors++;
    $display("%s: ready still low %0d cycles after reset release", test_name, waited);
  end else begin
    // From here on ready must stay high.
    ready_seen = 1'b1;
    for (int n = 0; n < 10; n++) begin
      issue_read(ADDR_W'($urandom % NUM_ADDR));
      next_cycle();
    end
    drain_pipeline();
  end
  end_test();
endtask

task automatic count_each_port();
  logic [ADDR_W-1:0] a;
  begin_test("count_each_port");
  for (int p = 0; p < NUM_PORTS; p++) begin
    a = ADDR_W'($urandom % NUM_ADDR);
    issue_count(p, a, WIDTH'($urandom));
    next_cycle();
    drain_pipeline();
    issue_read(a);
    next_cycle();
    drain_pipeline();
  end
  end_test();
endtask

// Every port hits one row back to back, so reads must see in-flight write-backs.
task automatic burst_same_row();
  logic [ADDR_W-1:0] a;
  begin_test("burst_same_row");
  a = ADDR_W'($urandom % NUM_ADDR);
  for (int n = 0; n < 8; n++) begin
    for (int p = 0; p < NUM_PORTS; p++) issue_count(p, a, WIDTH'($urandom));
    next_cycle();
  end
  issue_read(a);
  next_cycle();
  drain_pipeline();
  end_test();
endtask

task automatic write_then_count();
  logic [ADDR_W-1:0] a;
  begin_test("write_then_count");
  a = ADDR_W'($urandom % NUM_ADDR);
  issue_write(a, WIDTH'($urandom));
  next_cycle();
  for (int p = 0; p < NUM_PORTS; p++) begin
    issue_count(p, a, WIDTH'($urandom));
    next_cycle();
  end
  issue_read(a);
  next_cycle();
  drain_pipeline();
  end_test();
endtask

task automatic random_command_mix();
  int                   kind;
  logic [NUM_PORTS-1:0] mask;
  logic [ADDR_W-1:0]    a;
  begin_test("random_command_mix");
  for (int n = 0; n < 200; n++) begin
    kind = int'($urandom % 4);
    a    = ADDR_W'($urandom % HOT_ROWS);
    case (kind)
      1: issue_read(a);
      2: issue_write(a, WIDTH'($urandom));
      3: begin
        mask = NUM_PORTS'($urandom % (1 << NUM_PORTS));
        if (mask == '0) mask = 1;
        for (int p = 0; p < NUM_PORTS; p++) begin
          if (mask[p]) issue_count(p, ADDR_W'($urandom % HOT_ROWS), WIDTH'($urandom));
        end
      end
      default: begin
        // Idle cycle.
      end
    endcase
    next_cycle();
  end
  drain_pipeline();
  end_test();
endtask

//--- testbench/counter_memory_tb.sv
`timescale 1ns/100ps

module counter_memory_tb;
  import counter_memory_pkg::*;

  localparam int WIDTH     = default_width;
  localparam int NUM_ADDR  = default_num_addr;
  localparam int NUM_PORTS = default_num_cnt_ports;
  localparam int ADDR_W    = $clog2(NUM_ADDR);
  localparam int CT_LAT    = default_sram_delay + 1;
  localparam int RD_LAT    = default_sram_delay + 2;
  localparam int SLOTS     = 8;
  localparam int HOT_ROWS  = 8;

  logic                        clk;
  logic                        reset;
  logic                        ready;
  logic [NUM_PORTS-1:0]        cnt;
  logic [NUM_PORTS*ADDR_W-1:0] ct_adr;
  logic [NUM_PORTS*WIDTH-1:0]  imm;
  logic [NUM_PORTS-1:0]        ct_vld;
  logic                        read;
  logic                        write;
  logic [ADDR_W-1:0]           addr;
  logic [WIDTH-1:0]            din;
  logic                        rd_vld;
  logic [WIDTH-1:0]            rd_dout;

  // Reference rows, and the outputs expected in each upcoming cycle.
  logic [WIDTH-1:0]     model   [NUM_ADDR];
  logic                 exp_rd  [SLOTS];
  logic [WIDTH-1:0]     exp_val [SLOTS];
  logic [NUM_PORTS-1:0] exp_ct  [SLOTS];
  logic                 ready_seen;
  int                   cycle_no;
  int                   checks;
  int                   errors;
  int                   errors_at_start;
  int                   tests_run;
  string                test_name;

  counter_memory_top #(
    .WIDTH         (WIDTH),
    .NUM_ADDR      (NUM_ADDR),
    .NUM_CNT_PORTS (NUM_PORTS),
    .SRAM_DELAY    (default_sram_delay)
  ) uut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ----------------------------------------------------------
  // Compare tasks.
  // ----------------------------------------------------------
  task automatic compare_word(string what, logic [WIDTH-1:0] expected,
                              logic [WIDTH-1:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("mismatch %s %s expected %0h actual %0h", test_name, what, expected, actual);
    end
  endtask

  task automatic compare_bit(string what, logic expected, logic actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("mismatch %s %s expected %0b actual %0b", test_name, what, expected, actual);
    end
  endtask

  // Advance to the next falling edge, check the strobes due there, idle the inputs.
  task automatic next_cycle();
    int slot;
    @(negedge clk);
    cycle_no++;
    slot = cycle_no % SLOTS;
    if (ready_seen) compare_bit("ready", 1'b1, ready);
    compare_bit("rd_vld", exp_rd[slot], rd_vld);
    if (exp_rd[slot]) compare_word("rd_dout", exp_val[slot], rd_dout);
    for (int p = 0; p < NUM_PORTS; p++) begin
      compare_bit($sformatf("ct_vld[%0d]", p), exp_ct[slot][p], ct_vld[p]);
    end
    exp_rd[slot] = 1'b0;
    exp_ct[slot] = '0;
    cnt   = '0;
    read  = 1'b0;
    write = 1'b0;
  endtask

  task automatic issue_read(logic [ADDR_W-1:0] a);
    int slot;
    slot = (cycle_no + RD_LAT) % SLOTS;
    read = 1'b1;
    addr = a;
    exp_rd[slot]  = 1'b1;
    exp_val[slot] = model[a];
  endtask

  task automatic issue_write(logic [ADDR_W-1:0] a, logic [WIDTH-1:0] v);
    write = 1'b1;
    addr  = a;
    din   = v;
    model[a] = v;
  endtask

  task automatic issue_count(int p, logic [ADDR_W-1:0] a, logic [WIDTH-1:0] v);
    int slot;
    slot = (cycle_no + CT_LAT) % SLOTS;
    cnt[p] = 1'b1;
    ct_adr[p*ADDR_W +: ADDR_W] = a;
    imm[p*WIDTH +: WIDTH] = v;
    model[a] = model[a] + v;
    exp_ct[slot][p] = 1'b1;
  endtask

  function automatic bit outputs_pending();
    bit any;
    any = 1'b0;
    for (int s = 0; s < SLOTS; s++) begin
      if (exp_rd[s] || exp_ct[s] != '0) any = 1'b1;
    end
    return any;
  endfunction

  task automatic drain_pipeline();
    int waited;
    waited = 0;
    while (outputs_pending() && waited < 2 * SLOTS) begin
      next_cycle();
      waited++;
    end
    if (outputs_pending()) begin
      errors++;
      $display("%s: expected strobes still outstanding after %0d cycles", test_name, waited);
    end
  endtask

  task automatic begin_test(string name);
    test_name = name;
    errors_at_start = errors;
    tests_run++;
  endtask

  task automatic end_test();
    $display("test %s done with %0d errors", test_name, errors - errors_at_start);
  endtask

  `include "counter_memory_tests.svh"

  initial begin
    void'($urandom(32'h1375_b447));
    reset  = 1'b1;
    cnt    = '0;
    ct_adr = '0;
    imm    = '0;
    read   = 1'b0;
    write  = 1'b0;
    addr   = '0;
    din    = '0;
    ready_seen = 1'b0;
    cycle_no   = 0;
    checks     = 0;
    errors     = 0;
    tests_run  = 0;
    for (int s = 0; s < SLOTS; s++) begin
      exp_rd[s] = 1'b0;
      exp_ct[s] = '0;
    end
    for (int r = 0; r < NUM_ADDR; r++) model[r] = '0;
    repeat (3) @(negedge clk);
    reset = 1'b0;

    check_clear_after_reset();
    if (ready) begin
      count_each_port();
      burst_same_row();
      write_then_count();
      random_command_mix();
    end

    $display("tests run %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- compile.f
logic/counter_memory_pkg.sv
logic/sram_1r1w.sv
logic/row_clear_sequencer.sv
logic/partial_sum_bank.sv
logic/read_sum_collector.sv
logic/counter_memory_top.sv
+incdir+testbench
testbench/counter_memory_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module counter_memory_tb -f compile.f &&
sim_out="$(./obj_dir/Vcounter_memory_tb)" &&
printf '%s\n' "$sim_out" &&
printf '%s\n' "$sim_out" | grep -q "All checks passed" || exit 1
